/* verilog/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

////////////////////////////////////////////////////////////
// Register file
////////////////////////////////////////////////////////////

// Architectural registers, register 0 hardwired to zero
`define CORE_NUM_REGS 16

////////////////////////////////////////////////////////////
// Multiplier sequencing
////////////////////////////////////////////////////////////

// Shift-add steps per multiply
`define CORE_MUL_STEPS 8

// Multiplier bits retired per step (radix 16)
`define CORE_MUL_STEP_BITS 4

// Step counter width, enough for CORE_MUL_STEPS states
`define CORE_TIMER_BITS 3

`endif

/* verilog/core_pkg.sv */
`include "core_consts.svh"

package core_pkg;

	// Data word and register index
	typedef logic [31:0] word_t;
	typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_idx_t;

	// Retired instruction count that wraps at 256
	typedef logic [7:0] count_t;

	// Unlisted opcode values act as NOP
	typedef enum logic [3:0] {
		NOP  = 4'd0,
		ADD  = 4'd1,
		SUB  = 4'd2,
		AND  = 4'd3,
		XOR  = 4'd4,
		ADDI = 4'd5,
		LUI  = 4'd6,
		MUL  = 4'd7,
		WFI  = 4'd15
	} opcode_e;

	// Register form
	typedef struct packed {
		opcode_e     opcode;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		logic [15:0] unused;
	} insn_r_t;

	// Immediate form sharing the upper fields
	typedef struct packed {
		opcode_e     opcode;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		// Bits 19 to 16 carry nothing here
		logic [3:0]  unused;
		logic [15:0] imm;
	} insn_i_t;

	// One instruction word seen both ways
	typedef union packed {
		insn_r_t r;
		insn_i_t i;
	} insn_u;

endpackage

/* verilog/pipe_ctrl.sv */
`timescale 1ns/1ps

module pipe_ctrl (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              inst_valid,
	input  core_pkg::opcode_e inst_op,
	input  logic              mul_done,
	output logic              accept,
	output logic              busy,
	output logic              halt,
	output logic              mul_start,
	output logic              exec_mul
);

	typedef enum logic [1:0] {
		RUN,
		MUL_LOAD,
		MUL_STEP,
		HALTED
	} state_e;

	state_e state;
	state_e state_nxt;

	// Take a new word only when idle
	assign accept = inst_valid && !busy && !halt;

	// Busy comes straight off the state flops
	assign busy = (state != RUN);

	// Operand load happens in the cycle after a MUL is accepted
	assign mul_start = (state == MUL_LOAD);

	// Write-back source is the multiplier until it is done
	assign exec_mul = (state == MUL_LOAD) || (state == MUL_STEP);

	////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			RUN: begin
				if (accept && inst_op == core_pkg::MUL)
					state_nxt = MUL_LOAD;
				else if (accept && inst_op == core_pkg::WFI)
					state_nxt = HALTED;
			end
			MUL_LOAD: state_nxt = MUL_STEP;
			// Leave on the cycle the product is written back
			MUL_STEP: begin
				if (mul_done)
					state_nxt = RUN;
			end
			// Only reset gets out of here
			default: state_nxt = HALTED;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= RUN;
			halt  <= 1'b0;
		end else begin
			state <= state_nxt;
			// Halt one edge after WFI, once the older ALU op has retired
			halt  <= halt || (state == HALTED);
		end
	end

endmodule

/* verilog/mul_timer.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module mul_timer (
	input  logic clock,
	input  logic rst_n,
	input  logic start,
	output logic step,
	output logic last
);

	logic                        running;
	logic [`CORE_TIMER_BITS-1:0] cnt;

	// One step per cycle while running
	assign step = running;
	assign last = running && (cnt == `CORE_TIMER_BITS'(`CORE_MUL_STEPS - 1));

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			running <= 1'b0;
			cnt     <= '0;
		end else if (start) begin
			running <= 1'b1;
			cnt     <= '0;
		end else if (running) begin
			// Stop after the final step
			if (last)
				running <= 1'b0;
			cnt <= cnt + 1'b1;
		end
	end

endmodule

/* verilog/mul_unit.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module mul_unit (
	input  logic            clock,
	input  logic            rst_n,
	input  logic            load,
	input  logic            step,
	input  logic            last,
	input  core_pkg::word_t a,
	input  core_pkg::word_t b,
	output core_pkg::word_t product,
	output logic            mul_done
);

	// Multiplicand, shifted up one digit per step
	core_pkg::word_t mcand;
	// Multiplier bits not yet consumed
	core_pkg::word_t mplier;
	// Running sum of partial products
	core_pkg::word_t acc;
	core_pkg::word_t partial;

	// Multiplicand times the low digit
	assign partial = mcand * core_pkg::word_t'(mplier[`CORE_MUL_STEP_BITS-1:0]);

	assign product = acc;

	always_ff @(posedge clock) begin
		if (load) begin
			mcand  <= a;
			mplier <= b;
			acc    <= '0;
		end else if (step) begin
			acc    <= acc + partial;
			mcand  <= mcand << `CORE_MUL_STEP_BITS;
			mplier <= mplier >> `CORE_MUL_STEP_BITS;
		end
	end

	// Done lines up with the final sum
	always_ff @(posedge clock) begin
		if (!rst_n)
			mul_done <= 1'b0;
		else
			mul_done <= last;
	end

endmodule

/* verilog/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               accept,
	input  core_pkg::insn_u    inst,
	output logic               issue_valid,
	output core_pkg::opcode_e  op,
	output core_pkg::reg_idx_t rd,
	output core_pkg::reg_idx_t rs1,
	output core_pkg::reg_idx_t rs2,
	output core_pkg::word_t    imm
);

	core_pkg::insn_u inst_q;

	////////////////////////////////////////////////////////////
	// Issue pipeline register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n)
			issue_valid <= 1'b0;
		else
			issue_valid <= accept;
	end

	// Fields held until the next accept
	always_ff @(posedge clock) begin
		if (accept)
			inst_q <= inst;
	end

	// Register fields from the register form
	assign op  = inst_q.r.opcode;
	assign rd  = inst_q.r.rd;
	assign rs1 = inst_q.r.rs1;
	assign rs2 = inst_q.r.rs2;

	// Immediate from the immediate form
	always_comb begin
		if (inst_q.i.opcode == core_pkg::LUI)
			imm = {inst_q.i.imm, 16'h0000};
		else
			imm = {{16{inst_q.i.imm[15]}}, inst_q.i.imm};
	end

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module reg_file (
	input  logic               clock,
	input  logic               rst_n,
	input  core_pkg::reg_idx_t rs1,
	input  core_pkg::reg_idx_t rs2,
	input  logic               wr_en,
	input  core_pkg::reg_idx_t wr_idx,
	input  core_pkg::word_t    wr_data,
	output core_pkg::word_t    rs1_data,
	output core_pkg::word_t    rs2_data
);

	core_pkg::word_t regs [`CORE_NUM_REGS];

	// Write port, register 0 never changes
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < `CORE_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Combinational reads, zero for index 0
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* verilog/exec_alu.sv */
`timescale 1ns/1ps

module exec_alu (
	input  logic              valid,
	input  core_pkg::opcode_e op,
	input  core_pkg::word_t   a,
	input  core_pkg::word_t   b,
	input  core_pkg::word_t   imm,
	output logic              alu_valid,
	output core_pkg::word_t   result
);

	logic is_alu;

	// Single-cycle ops only, MUL goes to the multiplier
	always_comb begin
		is_alu = 1'b1;
		result = '0;
		case (op)
			core_pkg::ADD:  result = a + b;
			core_pkg::SUB:  result = a - b;
			core_pkg::AND:  result = a & b;
			core_pkg::XOR:  result = a ^ b;
			core_pkg::ADDI: result = a + imm;
			// Already placed in the upper half
			core_pkg::LUI:  result = imm;
			default:        is_alu = 1'b0;
		endcase
	end

	assign alu_valid = valid && is_alu;

endmodule

/* verilog/retire_stage.sv */
`timescale 1ns/1ps

module retire_stage (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               alu_valid,
	input  core_pkg::word_t    alu_result,
	input  core_pkg::reg_idx_t rd,
	input  logic               exec_mul,
	input  logic               mul_done,
	input  core_pkg::word_t    product,
	output logic               wr_en,
	output core_pkg::reg_idx_t wr_idx,
	output core_pkg::word_t    wr_data,
	output logic               retire_valid,
	output core_pkg::reg_idx_t retire_rd,
	output core_pkg::word_t    retire_value,
	output core_pkg::count_t   inst_count
);

	core_pkg::reg_idx_t mul_rd;
	logic               mul_pending;

	// Grab the destination on the first cycle of a multiply
	always_ff @(posedge clock) begin
		if (exec_mul && !mul_pending)
			mul_rd <= rd;
	end

	always_ff @(posedge clock) begin
		if (!rst_n)
			mul_pending <= 1'b0;
		else
			mul_pending <= exec_mul && !mul_done;
	end

	////////////////////////////////////////////////////////////
	// Write-back select
	////////////////////////////////////////////////////////////

	assign wr_en   = exec_mul ? mul_done : alu_valid;
	assign wr_idx  = exec_mul ? mul_rd : rd;
	assign wr_data = exec_mul ? product : alu_result;

	// Retire register, one cycle behind the write
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			retire_valid <= 1'b0;
			inst_count   <= '0;
		end else begin
			retire_valid <= wr_en;
			inst_count   <= inst_count + core_pkg::count_t'(wr_en);
		end
	end

	always_ff @(posedge clock) begin
		retire_rd    <= wr_idx;
		retire_value <= wr_data;
	end

endmodule

/* verilog/tiny_core.sv */
`timescale 1ns/1ps

module tiny_core (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               inst_valid,
	input  core_pkg::insn_u    inst,
	output logic               busy,
	output logic               halt,
	output logic               retire_valid,
	output core_pkg::reg_idx_t retire_rd,
	output core_pkg::word_t    retire_value,
	output core_pkg::count_t   inst_count
);

	// Control
	logic accept;
	logic mul_start;
	logic exec_mul;

	// Multiplier
	logic            step;
	logic            last;
	logic            mul_done;
	core_pkg::word_t product;

	// Issue
	logic               issue_valid;
	core_pkg::opcode_e  op;
	core_pkg::reg_idx_t rd;
	core_pkg::reg_idx_t rs1;
	core_pkg::reg_idx_t rs2;
	core_pkg::word_t    imm;
	core_pkg::word_t    rs1_data;
	core_pkg::word_t    rs2_data;

	// Execute and write-back
	logic               alu_valid;
	core_pkg::word_t    alu_result;
	logic               wr_en;
	core_pkg::reg_idx_t wr_idx;
	core_pkg::word_t    wr_data;

	////////////////////////////////////////////////////////////
	// Control and multiply sequencing
	////////////////////////////////////////////////////////////

	pipe_ctrl u_pipe_ctrl (
		.clock      (clock),
		.rst_n      (rst_n),
		.inst_valid (inst_valid),
		.inst_op    (inst.r.opcode),
		.mul_done   (mul_done),
		.accept     (accept),
		.busy       (busy),
		.halt       (halt),
		.mul_start  (mul_start),
		.exec_mul   (exec_mul)
	);

	mul_timer u_mul_timer (
		.clock (clock),
		.rst_n (rst_n),
		.start (mul_start),
		.step  (step),
		.last  (last)
	);

	// Operands come from the register file read at issue
	mul_unit u_mul_unit (
		.clock    (clock),
		.rst_n    (rst_n),
		.load     (mul_start),
		.step     (step),
		.last     (last),
		.a        (rs1_data),
		.b        (rs2_data),
		.product  (product),
		.mul_done (mul_done)
	);

	////////////////////////////////////////////////////////////
	// Issue, execute, retire
	////////////////////////////////////////////////////////////

	issue_stage u_issue_stage (
		.clock       (clock),
		.rst_n       (rst_n),
		.accept      (accept),
		.inst        (inst),
		.issue_valid (issue_valid),
		.op          (op),
		.rd          (rd),
		.rs1         (rs1),
		.rs2         (rs2),
		.imm         (imm)
	);

	reg_file u_reg_file (
		.clock    (clock),
		.rst_n    (rst_n),
		.rs1      (rs1),
		.rs2      (rs2),
		.wr_en    (wr_en),
		.wr_idx   (wr_idx),
		.wr_data  (wr_data),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	exec_alu u_exec_alu (
		.valid     (issue_valid),
		.op        (op),
		.a         (rs1_data),
		.b         (rs2_data),
		.imm       (imm),
		.alu_valid (alu_valid),
		.result    (alu_result)
	);

	retire_stage u_retire_stage (
		.clock        (clock),
		.rst_n        (rst_n),
		.alu_valid    (alu_valid),
		.alu_result   (alu_result),
		.rd           (rd),
		.exec_mul     (exec_mul),
		.mul_done     (mul_done),
		.product      (product),
		.wr_en        (wr_en),
		.wr_idx       (wr_idx),
		.wr_data      (wr_data),
		.retire_valid (retire_valid),
		.retire_rd    (retire_rd),
		.retire_value (retire_value),
		.inst_count   (inst_count)
	);

endmodule

/* tb/tiny_core_assert.sv */
`timescale 1ns/1ps

module tiny_core_assert (
	input logic clock,
	input logic rst_n,
	input logic busy,
	input logic halt,
	input logic retire_valid
);

	// Failure tally, read by the testbench at the end of the run
	int assert_fails = 0;

	////////////////////////////////////////////////////////////
	// Control output rules
	////////////////////////////////////////////////////////////

	// A halted core never looks idle
	halt_busy: assert property (@(posedge clock) disable iff (!rst_n) halt |-> busy)
		else begin
			$error("halt high while busy low");
			assert_fails++;
		end

	// Only reset clears halt
	halt_sticky: assert property (@(posedge clock) disable iff (!rst_n) halt |=> halt)
		else begin
			$error("halt dropped without reset");
			assert_fails++;
		end

	// At most one retirement slips out under busy
	retire_short: assert property (@(posedge clock) disable iff (!rst_n)
		(retire_valid && busy) |=> !retire_valid)
		else begin
			$error("retire_valid held two cycles while busy");
			assert_fails++;
		end

	// Pipeline drained once halted
	halt_quiet: assert property (@(posedge clock) disable iff (!rst_n) halt |=> !retire_valid)
		else begin
			$error("retire_valid seen after halt");
			assert_fails++;
		end

endmodule

bind tiny_core tiny_core_assert u_tiny_core_assert (
	.clock        (clock),
	.rst_n        (rst_n),
	.busy         (busy),
	.halt         (halt),
	.retire_valid (retire_valid)
);

/* tb/tiny_core_tb.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module tiny_core_tb;

	logic               clock = 1'b0;
	logic               rst_n;
	logic               inst_valid;
	core_pkg::insn_u    inst;
	logic               busy;
	logic               halt;
	logic               retire_valid;
	core_pkg::reg_idx_t retire_rd;
	core_pkg::word_t    retire_value;
	core_pkg::count_t   inst_count;

	// Stimulus table, one word per row plus whether it should retire
	core_pkg::insn_u prog_words[$];
	bit              prog_retires[$];

	// Reference model state and expected retirements in program order
	core_pkg::word_t    model_regs [`CORE_NUM_REGS];
	core_pkg::reg_idx_t exp_rd_q[$];
	core_pkg::word_t    exp_val_q[$];
	core_pkg::count_t   retired_total;
	core_pkg::count_t   table_total;

	integer seed;
	int     cycle_count;
	int     timeout_limit;

	tiny_core u_tiny_core (
		.clock        (clock),
		.rst_n        (rst_n),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.busy         (busy),
		.halt         (halt),
		.retire_valid (retire_valid),
		.retire_rd    (retire_rd),
		.retire_value (retire_value),
		.inst_count   (inst_count)
	);

	// 40 ns period
	always #20 clock = ~clock;

	////////////////////////////////////////////////////////////
	// Failure handling and compare tasks
	////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input core_pkg::word_t got,
		input core_pkg::word_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_idx(input string name, input core_pkg::reg_idx_t got,
		input core_pkg::reg_idx_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%01h expected 0x%01h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input core_pkg::count_t got,
		input core_pkg::count_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%01h expected 0x%01h", name, got, exp);
			abort_run();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Instruction builders and table
	////////////////////////////////////////////////////////////

	function automatic core_pkg::insn_u reg_form(input core_pkg::opcode_e op,
		input int rd, input int rs1, input int rs2);
		core_pkg::insn_u w;
		w          = '0;
		w.r.opcode = op;
		w.r.rd     = core_pkg::reg_idx_t'(rd);
		w.r.rs1    = core_pkg::reg_idx_t'(rs1);
		w.r.rs2    = core_pkg::reg_idx_t'(rs2);
		return w;
	endfunction

	function automatic core_pkg::insn_u imm_form(input core_pkg::opcode_e op,
		input int rd, input int rs1, input logic [15:0] imm);
		core_pkg::insn_u w;
		w          = '0;
		w.i.opcode = op;
		w.i.rd     = core_pkg::reg_idx_t'(rd);
		w.i.rs1    = core_pkg::reg_idx_t'(rs1);
		w.i.imm    = imm;
		return w;
	endfunction

	function logic [15:0] next_imm();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	task automatic add_row(input core_pkg::insn_u w, input bit retires);
		prog_words.push_back(w);
		prog_retires.push_back(retires);
	endtask

	task automatic build_table();
		// Constants, then a dependent chain issued back to back
		add_row(imm_form(core_pkg::ADDI, 1, 0, next_imm()), 1);
		add_row(imm_form(core_pkg::LUI, 2, 0, next_imm()), 1);
		add_row(imm_form(core_pkg::ADDI, 3, 2, next_imm()), 1);
		add_row(reg_form(core_pkg::ADD, 4, 1, 3), 1);
		add_row(reg_form(core_pkg::SUB, 5, 4, 1), 1);
		add_row(reg_form(core_pkg::AND, 6, 5, 3), 1);
		add_row(reg_form(core_pkg::XOR, 7, 6, 4), 1);
		// Register 0 retires the sum but keeps reading zero
		add_row(imm_form(core_pkg::ADDI, 0, 1, 16'h0005), 1);
		add_row(reg_form(core_pkg::ADD, 8, 0, 1), 1);
		// Multiplies, a consumer waits behind each
		add_row(reg_form(core_pkg::MUL, 9, 1, 3), 1);
		add_row(reg_form(core_pkg::ADD, 10, 9, 1), 1);
		add_row(imm_form(core_pkg::ADDI, 11, 0, next_imm()), 1);
		add_row(imm_form(core_pkg::LUI, 12, 0, next_imm()), 1);
		add_row(imm_form(core_pkg::ADDI, 12, 12, next_imm()), 1);
		add_row(reg_form(core_pkg::MUL, 13, 11, 12), 1);
		add_row(reg_form(core_pkg::MUL, 14, 13, 2), 1);
		// NOP and unknown opcodes
		add_row(imm_form(core_pkg::NOP, 5, 1, next_imm()), 0);
		add_row(reg_form(core_pkg::opcode_e'(4'd8), 6, 1, 2), 0);
		add_row(reg_form(core_pkg::opcode_e'(4'd12), 7, 3, 4), 0);
		add_row(reg_form(core_pkg::XOR, 15, 14, 10), 1);
		add_row(reg_form(core_pkg::SUB, 1, 15, 9), 1);
		add_row(reg_form(core_pkg::AND, 2, 1, 7), 1);
		add_row(reg_form(core_pkg::MUL, 3, 1, 15), 1);
		// ALU op still in flight when WFI arrives
		add_row(imm_form(core_pkg::ADDI, 5, 3, next_imm()), 1);
		add_row(reg_form(core_pkg::WFI, 0, 0, 0), 0);
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	task automatic model_accept(input core_pkg::insn_u w);
		core_pkg::word_t a;
		core_pkg::word_t b;
		core_pkg::word_t v;
		bit              writes;
		a      = model_regs[w.r.rs1];
		b      = model_regs[w.r.rs2];
		v      = '0;
		writes = 1'b1;
		case (w.r.opcode)
			core_pkg::ADD:  v = a + b;
			core_pkg::SUB:  v = a - b;
			core_pkg::AND:  v = a & b;
			core_pkg::XOR:  v = a ^ b;
			core_pkg::ADDI: v = a + {{16{w.i.imm[15]}}, w.i.imm};
			core_pkg::LUI:  v = {w.i.imm, 16'h0000};
			// Low half of the product only
			core_pkg::MUL:  v = a * b;
			default:        writes = 1'b0;
		endcase
		if (writes) begin
			exp_rd_q.push_back(w.r.rd);
			exp_val_q.push_back(v);
			// Register 0 stays zero in the model
			if (w.r.rd != '0)
				model_regs[w.r.rd] = v;
		end
	endtask

	// Present at a rising edge, hold while busy, return on the accepting edge
	task automatic issue_word(input core_pkg::insn_u w);
		inst_valid <= 1'b1;
		inst       <= w;
		@(negedge clock);
		while (busy)
			@(negedge clock);
		@(posedge clock);
		model_accept(w);
	endtask

	////////////////////////////////////////////////////////////
	// Retirement checker and watchdog
	////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		if (rst_n === 1'b1 && retire_valid === 1'b1) begin
			if (exp_rd_q.size() == 0) begin
				$display("Retirement seen with no instruction left to retire");
				abort_run();
			end else begin
				retired_total = retired_total + 1'b1;
				check_idx("retire_rd", retire_rd, exp_rd_q.pop_front());
				check_word("retire_value", retire_value, exp_val_q.pop_front());
				check_count("inst_count", inst_count, retired_total);
			end
		end
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("Run did not finish within the cycle limit");
			abort_run();
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		rst_n         = 1'b0;
		inst_valid    = 1'b0;
		inst          = '0;
		seed          = 18;
		cycle_count   = 0;
		retired_total = '0;
		table_total   = '0;
		for (int i = 0; i < `CORE_NUM_REGS; i++)
			model_regs[i] = '0;
		build_table();
		timeout_limit = prog_words.size() * (`CORE_MUL_STEPS + 4) + 50;
		foreach (prog_retires[i])
			table_total = table_total + core_pkg::count_t'(prog_retires[i]);

		repeat (5) @(posedge clock);
		rst_n <= 1'b1;

		// Idle state after reset
		@(negedge clock);
		check_bit("busy", busy, 1'b0);
		check_bit("halt", halt, 1'b0);
		check_bit("retire_valid", retire_valid, 1'b0);
		check_count("inst_count", inst_count, 8'h00);

		@(posedge clock);
		foreach (prog_words[i])
			issue_word(prog_words[i]);

		// Keep offering work after WFI, none may be taken
		inst <= reg_form(core_pkg::ADD, 6, 1, 1);
		@(negedge clock);
		while (!halt)
			@(negedge clock);
		repeat (8) begin
			check_bit("halt", halt, 1'b1);
			check_bit("busy", busy, 1'b1);
			@(negedge clock);
		end
		@(posedge clock);
		inst_valid <= 1'b0;
		@(negedge clock);

		if (exp_rd_q.size() != 0) begin
			$display("Expected retirement missing after halt");
			abort_run();
		end
		check_count("inst_count", inst_count, retired_total);
		check_count("inst_count", inst_count, table_total);

		if (u_tiny_core.u_tiny_core_assert.assert_fails == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("TEST FAILED");
			$fatal(1);
		end
	end

endmodule

/* list.f */
+incdir+verilog
verilog/core_pkg.sv
verilog/pipe_ctrl.sv
verilog/mul_timer.sv
verilog/mul_unit.sv
verilog/issue_stage.sv
verilog/reg_file.sv
verilog/exec_alu.sv
verilog/retire_stage.sv
verilog/tiny_core.sv
tb/tiny_core_assert.sv
tb/tiny_core_tb.sv
